// File: alu.sv
module alu (
    input  cpu_pkg::alu_op_t          op,
    input  logic [cpu_pkg::xlen-1:0]  a,
    input  logic [cpu_pkg::xlen-1:0]  b,
    output logic [cpu_pkg::xlen-1:0]  result,
    output logic                      zero
);

    always_comb begin
        case (op)
            cpu_pkg::alu_add:    result = a + b;
            cpu_pkg::alu_sub:    result = a - b;
            cpu_pkg::alu_and:    result = a & b;
            cpu_pkg::alu_or:     result = a | b;
            cpu_pkg::alu_xor:    result = a ^ b;
            // signed compare
            cpu_pkg::alu_slt:    result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            cpu_pkg::alu_sll:    result = a << b[4:0];
            cpu_pkg::alu_srl:    result = a >> b[4:0];
            cpu_pkg::alu_pass_b: result = b;
            default:             result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: cpu_ctrl.sv
module cpu_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::ctrl_t      ctrl,
    input  logic                done,
    output cpu_pkg::cpu_state_t state,
    output logic                fetch_req,
    output logic                data_req,
    output logic                pc_en,
    output logic                reg_we,
    output logic                halted
);

    cpu_pkg::cpu_state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpu_pkg::st_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cpu_pkg::st_fetch: begin
                if (done) begin
                    next_state = cpu_pkg::st_decode;
                end
            end
            cpu_pkg::st_decode: begin
                // illegal words come out of decode as ecall as well
                if (ctrl.kind == cpu_pkg::kind_ecall) begin
                    next_state = cpu_pkg::st_halt;
                end else begin
                    next_state = cpu_pkg::st_execute;
                end
            end
            cpu_pkg::st_execute: begin
                if (ctrl.mem_read || ctrl.mem_write) begin
                    next_state = cpu_pkg::st_memory;
                end else begin
                    next_state = cpu_pkg::st_writeback;
                end
            end
            cpu_pkg::st_memory: begin
                if (done) begin
                    next_state = cpu_pkg::st_writeback;
                end
            end
            cpu_pkg::st_writeback: begin
                next_state = cpu_pkg::st_fetch;
            end
            default: begin
                next_state = cpu_pkg::st_halt;
            end
        endcase
    end

    // bus requests stay up for the whole state, mem_access ignores them after done
    assign fetch_req = (state == cpu_pkg::st_fetch);
    assign data_req  = (state == cpu_pkg::st_memory);

    assign pc_en  = (state == cpu_pkg::st_writeback);
    assign reg_we = (state == cpu_pkg::st_writeback) && ctrl.reg_write;
    assign halted = (state == cpu_pkg::st_halt);

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 1 << reg_addr_w;

    // reset value of the instruction register, addi x0, x0, 0
    localparam logic [xlen-1:0] nop_instr   = 32'h0000_0013;
    localparam logic [xlen-1:0] ecall_instr = 32'h0000_0073;

    // only full-word transfers on the bus
    localparam logic [3:0] sel_all = 4'hf;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_halt
    } cpu_state_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [3:0] {
        kind_alu,
        kind_load,
        kind_store,
        kind_branch_eq,
        kind_branch_ne,
        kind_jal,
        kind_jalr,
        kind_lui,
        kind_ecall
    } inst_kind_t;

    // rv32i major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_system = 7'b1110011
    } opcode_t;

    typedef struct packed {
        inst_kind_t              kind;
        alu_op_t                 alu_op;
        logic                    alu_src_imm;
        logic                    mem_read;
        logic                    mem_write;
        logic                    reg_write;
        logic                    branch_c;
        logic                    branch_uc;
        logic                    branch_relative;
        logic                    invert_zero;
        logic [reg_addr_w-1:0]   rd;
        logic [reg_addr_w-1:0]   rs1;
        logic [reg_addr_w-1:0]   rs2;
    } ctrl_t;

    typedef struct packed {
        logic                    mem_read;
        logic                    mem_write;
        logic                    reg_write;
        logic [reg_addr_w-1:0]   rd;
        logic                    branch;
        logic [xlen-1:0]         branch_addr;
        logic [xlen-1:0]         mem_addr;
        logic [xlen-1:0]         mem_write_data;
        logic [xlen-1:0]         reg_write_data;
    } exec_out_t;

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [3:0]              sel;
        logic [xlen-1:0]         adr;
        logic [xlen-1:0]         dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                    ack;
        logic [xlen-1:0]         dat_r;
    } wb_rsp_t;

endpackage

// File: cpu_props.sv
module cpu_props (
    input logic             clk,
    input logic             rst,
    input cpu_pkg::wb_req_t wb_o,
    input cpu_pkg::wb_rsp_t wb_i,
    input logic             halted
);
    timeunit 1ns;
    timeprecision 1ps;

    // failed assertions so far
    int fail_count = 0;

    stb_inside_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_o.stb |-> wb_o.cyc)
    else begin
        fail_count++;
        $error("stb is high while cyc is low");
    end

    // master holds the request until ack
    req_held: assert property (@(posedge clk) disable iff (rst)
        (wb_o.stb && !wb_i.ack) |=>
            ($stable(wb_o.adr) && $stable(wb_o.we) && $stable(wb_o.dat_w)))
    else begin
        fail_count++;
        $error("adr, we or dat_w changed while waiting for ack");
    end

    cyc_low_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !wb_o.cyc)
    else begin
        fail_count++;
        $error("cyc is high in the first cycle after reset");
    end

    halted_low_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !halted)
    else begin
        fail_count++;
        $error("halted is high in the first cycle after reset");
    end

    no_bus_when_halted: assert property (@(posedge clk) disable iff (rst)
        halted |-> !wb_o.stb)
    else begin
        fail_count++;
        $error("a bus cycle started after the core halted");
    end

endmodule

bind cpu_top cpu_props props (
    .clk    (clk),
    .rst    (rst),
    .wb_o   (wb_o),
    .wb_i   (wb_i),
    .halted (halted)
);

// File: cpu_top.sv
module cpu_top (
    input  logic              clk,
    input  logic              rst,
    output cpu_pkg::wb_req_t  wb_o,
    input  cpu_pkg::wb_rsp_t  wb_i,
    output logic              halted
);

    cpu_pkg::cpu_state_t      state;
    cpu_pkg::ctrl_t           ctrl;
    cpu_pkg::exec_out_t       ex;
    logic [cpu_pkg::xlen-1:0] pc;
    logic [cpu_pkg::xlen-1:0] imm;
    logic [cpu_pkg::xlen-1:0] reg1_data;
    logic [cpu_pkg::xlen-1:0] reg2_data;
    logic [cpu_pkg::xlen-1:0] rdata;
    logic [cpu_pkg::xlen-1:0] wb_data;
    logic                     fetch_req;
    logic                     data_req;
    logic                     done;
    logic                     pc_en;
    logic                     reg_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_en) begin
            pc <= ex.branch ? ex.branch_addr : pc + 32'd4;
        end
    end

    // loads take the bus data, everything else the execute result
    assign wb_data = ex.mem_read ? rdata : ex.reg_write_data;

    cpu_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .done      (done),
        .state     (state),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .pc_en     (pc_en),
        .reg_we    (reg_we),
        .halted    (halted)
    );

    decode u_decode (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .rdata (rdata),
        .done  (done),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    regfile u_regfile (
        .clk    (clk),
        .rs1    (ctrl.rs1),
        .rs2    (ctrl.rs2),
        .rd     (ex.rd),
        .we     (reg_we && ex.reg_write),
        .wdata  (wb_data),
        .rdata1 (reg1_data),
        .rdata2 (reg2_data)
    );

    exec u_exec (
        .clk       (clk),
        .state     (state),
        .pc        (pc),
        .imm       (imm),
        .ctrl      (ctrl),
        .reg1_data (reg1_data),
        .reg2_data (reg2_data),
        .result    (ex)
    );

    mem_access u_mem (
        .clk       (clk),
        .rst       (rst),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .pc        (pc),
        .ex        (ex),
        .wb_o      (wb_o),
        .wb_i      (wb_i),
        .done      (done),
        .rdata     (rdata)
    );

endmodule

// File: decode.sv
module decode (
    input  logic                      clk,
    input  logic                      rst,
    input  cpu_pkg::cpu_state_t       state,
    input  logic [cpu_pkg::xlen-1:0]  rdata,
    input  logic                      done,
    output cpu_pkg::ctrl_t            ctrl,
    output logic [cpu_pkg::xlen-1:0]  imm
);

    logic [cpu_pkg::xlen-1:0] instr;
    cpu_pkg::opcode_t         opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic [cpu_pkg::xlen-1:0] imm_i;
    logic [cpu_pkg::xlen-1:0] imm_s;
    logic [cpu_pkg::xlen-1:0] imm_b;
    logic [cpu_pkg::xlen-1:0] imm_j;
    logic [cpu_pkg::xlen-1:0] imm_u;

    always_ff @(posedge clk) begin
        if (rst) begin
            instr <= cpu_pkg::nop_instr;
        end else if (state == cpu_pkg::st_fetch && done) begin
            instr <= rdata;
        end
    end

    assign opcode = cpu_pkg::opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.kind   = cpu_pkg::kind_ecall;
        ctrl.alu_op = cpu_pkg::alu_add;
        ctrl.rd     = instr[11:7];
        ctrl.rs1    = instr[19:15];
        ctrl.rs2    = instr[24:20];
        imm         = '0;
        case (opcode)
            cpu_pkg::op_reg, cpu_pkg::op_imm: begin
                ctrl.kind        = cpu_pkg::kind_alu;
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = (opcode == cpu_pkg::op_imm);
                imm              = imm_i;
                case (funct3)
                    3'b000: begin
                        // sub only exists in register form
                        if (opcode == cpu_pkg::op_reg && funct7 == 7'b0100000) begin
                            ctrl.alu_op = cpu_pkg::alu_sub;
                        end
                    end
                    3'b111: ctrl.alu_op = cpu_pkg::alu_and;
                    3'b110: ctrl.alu_op = cpu_pkg::alu_or;
                    3'b100: ctrl.alu_op = cpu_pkg::alu_xor;
                    3'b010: ctrl.alu_op = cpu_pkg::alu_slt;
                    3'b001: ctrl.alu_op = cpu_pkg::alu_sll;
                    3'b101: ctrl.alu_op = cpu_pkg::alu_srl;
                    default: ctrl.alu_op = cpu_pkg::alu_add;
                endcase
                // shifts are register form only here, immediates stop at slti
                if (opcode == cpu_pkg::op_imm && (funct3 == 3'b001 || funct3 == 3'b101)) begin
                    ctrl      = '0;
                    ctrl.kind = cpu_pkg::kind_ecall;
                end
            end
            cpu_pkg::op_load: begin
                if (funct3 == 3'b010) begin
                    ctrl.kind        = cpu_pkg::kind_load;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_read    = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    imm              = imm_i;
                end
            end
            cpu_pkg::op_store: begin
                if (funct3 == 3'b010) begin
                    ctrl.kind        = cpu_pkg::kind_store;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.mem_write   = 1'b1;
                    imm              = imm_s;
                end
            end
            cpu_pkg::op_branch: begin
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    ctrl.kind            = funct3[0] ? cpu_pkg::kind_branch_ne
                                                     : cpu_pkg::kind_branch_eq;
                    ctrl.alu_op          = cpu_pkg::alu_sub;
                    ctrl.branch_c        = 1'b1;
                    ctrl.branch_relative = 1'b1;
                    ctrl.invert_zero     = funct3[0];
                    imm                  = imm_b;
                end
            end
            cpu_pkg::op_jal: begin
                ctrl.kind            = cpu_pkg::kind_jal;
                ctrl.branch_uc       = 1'b1;
                ctrl.branch_relative = 1'b1;
                ctrl.reg_write       = 1'b1;
                imm                  = imm_j;
            end
            cpu_pkg::op_jalr: begin
                if (funct3 == 3'b000) begin
                    ctrl.kind        = cpu_pkg::kind_jalr;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.branch_uc   = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    imm              = imm_i;
                end
            end
            cpu_pkg::op_lui: begin
                ctrl.kind        = cpu_pkg::kind_lui;
                ctrl.alu_op      = cpu_pkg::alu_pass_b;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                imm              = imm_u;
            end
            default: begin
                // ecall, op_system and anything unknown halt the core
                ctrl.kind = cpu_pkg::kind_ecall;
            end
        endcase
    end

endmodule

// File: exec.sv
module exec (
    input  logic                      clk,
    input  cpu_pkg::cpu_state_t       state,
    input  logic [cpu_pkg::xlen-1:0]  pc,
    input  logic [cpu_pkg::xlen-1:0]  imm,
    input  cpu_pkg::ctrl_t            ctrl,
    input  logic [cpu_pkg::xlen-1:0]  reg1_data,
    input  logic [cpu_pkg::xlen-1:0]  reg2_data,
    output cpu_pkg::exec_out_t        result
);

    logic [cpu_pkg::xlen-1:0] alu_b;
    logic [cpu_pkg::xlen-1:0] alu_result;
    logic                     alu_zero;

    assign alu_b = ctrl.alu_src_imm ? imm : reg2_data;

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (reg1_data),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::st_execute) begin
            result.mem_read  <= ctrl.mem_read;
            result.mem_write <= ctrl.mem_write;
            result.reg_write <= ctrl.reg_write;
            result.rd        <= ctrl.rd;
            // beq wants zero, bne wants nonzero
            result.branch    <= ctrl.branch_uc ||
                                (ctrl.branch_c && (alu_zero ^ ctrl.invert_zero));
            // jalr target comes straight from rs1 + imm
            result.branch_addr    <= ctrl.branch_relative ? pc + imm : alu_result;
            result.mem_addr       <= alu_result;
            result.mem_write_data <= reg2_data;
            result.reg_write_data <= ctrl.branch_uc ? pc + 32'd4 : alu_result;
        end else if (state == cpu_pkg::st_fetch) begin
            // enables drop while the next word is fetched, so they read low after reset
            result.mem_read  <= 1'b0;
            result.mem_write <= 1'b0;
            result.reg_write <= 1'b0;
            result.branch    <= 1'b0;
        end
    end

endmodule

// File: filelist.f
cpu_pkg.sv
alu.sv
regfile.sv
decode.sv
exec.sv
cpu_ctrl.sv
mem_access.sv
cpu_top.sv
cpu_props.sv
tb_cpu.sv

// File: mem_access.sv
module mem_access (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetch_req,
    input  logic                      data_req,
    input  logic [cpu_pkg::xlen-1:0]  pc,
    input  cpu_pkg::exec_out_t        ex,
    output cpu_pkg::wb_req_t          wb_o,
    input  cpu_pkg::wb_rsp_t          wb_i,
    output logic                      done,
    output logic [cpu_pkg::xlen-1:0]  rdata
);

    logic                     cyc_q;
    logic                     we_q;
    logic [cpu_pkg::xlen-1:0] adr_q;
    logic [cpu_pkg::xlen-1:0] dat_q;
    logic                     start;
    logic                     ack_seen;

    // no new cycle in the done cycle, the controller still holds its request
    assign start    = (fetch_req || data_req) && !cyc_q && !done;
    assign ack_seen = cyc_q && wb_i.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= ack_seen;
            if (ack_seen) begin
                cyc_q <= 1'b0;
                we_q  <= 1'b0;
            end else if (start) begin
                cyc_q <= 1'b1;
                we_q  <= data_req && ex.mem_write;
            end
        end
    end

    // address and write data stay put for the whole cycle
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= data_req ? ex.mem_addr : pc;
            dat_q <= ex.mem_write_data;
        end
        if (ack_seen) begin
            rdata <= wb_i.dat_r;
        end
    end

    assign wb_o.cyc   = cyc_q;
    assign wb_o.stb   = cyc_q;
    assign wb_o.we    = we_q;
    assign wb_o.sel   = cpu_pkg::sel_all;
    assign wb_o.adr   = adr_q;
    assign wb_o.dat_w = dat_q;

endmodule

// File: regfile.sv
module regfile (
    input  logic                            clk,
    input  logic [cpu_pkg::reg_addr_w-1:0]  rs1,
    input  logic [cpu_pkg::reg_addr_w-1:0]  rs2,
    input  logic [cpu_pkg::reg_addr_w-1:0]  rd,
    input  logic                            we,
    input  logic [cpu_pkg::xlen-1:0]        wdata,
    output logic [cpu_pkg::xlen-1:0]        rdata1,
    output logic [cpu_pkg::xlen-1:0]        rdata2
);

    logic [cpu_pkg::xlen-1:0] regs [cpu_pkg::reg_count];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // asynchronous reads, x0 forced to zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cpu -f filelist.f --Mdir obj_dir -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed!" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tb_cpu.sv
module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int mem_words  = 256;
    localparam int wait_limit = 500;

    localparam logic [6:0] opc_reg    = 7'b0110011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    logic             clk  = 1'b0;
    logic             rst  = 1'b1;
    cpu_pkg::wb_req_t wb_o;
    cpu_pkg::wb_rsp_t wb_i = '0;
    logic             halted;

    logic [31:0] mem [mem_words];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          load_idx     = 0;
    int          stores_seen  = 0;
    int          store_errors = 0;
    int          bus_errors   = 0;
    int          flow_errors  = 0;
    int          seed         = 91;
    int          wait_left    = 0;
    int          rnd;
    bit          busy         = 1'b0;
    bit          ok;

    cpu_top dut (
        .clk    (clk),
        .rst    (rst),
        .wb_o   (wb_o),
        .wb_i   (wb_i),
        .halted (halted)
    );

    always #50 clk = ~clk;

    // rv32i encoders
    function automatic logic [31:0] reg_op(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_reg};
    endfunction

    function automatic logic [31:0] imm_op(input int imm, input int rs1, input logic [2:0] f3,
                                           input int rd, input logic [6:0] opc);
        logic [31:0] v;
        v = imm;
        return {v[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] sw_op(input int imm, input int rs2, input int rs1);
        logic [31:0] v;
        v = imm;
        return {v[11:5], rs2[4:0], rs1[4:0], 3'b010, v[4:0], opc_store};
    endfunction

    function automatic logic [31:0] branch_op(input int imm, input int rs2, input int rs1,
                                              input logic [2:0] f3);
        logic [31:0] v;
        v = imm;
        return {v[12], v[10:5], rs2[4:0], rs1[4:0], f3, v[4:1], v[11], opc_branch};
    endfunction

    function automatic logic [31:0] jal_op(input int imm, input int rd);
        logic [31:0] v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], rd[4:0], opc_jal};
    endfunction

    function automatic logic [31:0] lui_op(input logic [19:0] upper, input int rd);
        return {upper, rd[4:0], opc_lui};
    endfunction

    task automatic place(input logic [31:0] word);
        mem[load_idx] = word;
        load_idx++;
    endtask

    task automatic load_program();
        // unused words are system opcodes, so a stray jump halts the core
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = {i[7:0], 24'h000073};
        end
        // preset word for the load at 0x240
        mem[144] = 32'h0000_1234;
        // x10 = 0x200 data base, x1 = 100, x2 = -7, x11 = 3
        place(imm_op(512, 0, 3'b000, 10, opc_imm));
        place(imm_op(100, 0, 3'b000, 1, opc_imm));
        place(imm_op(-7, 0, 3'b000, 2, opc_imm));
        place(imm_op(3, 0, 3'b000, 11, opc_imm));
        // register alu ops, each result stored in turn
        place(reg_op(7'h00, 2, 1, 3'b000, 3));
        place(sw_op(0, 3, 10));
        place(reg_op(7'h20, 2, 1, 3'b000, 3));
        place(sw_op(4, 3, 10));
        place(reg_op(7'h00, 2, 1, 3'b111, 3));
        place(sw_op(8, 3, 10));
        place(reg_op(7'h00, 2, 1, 3'b110, 3));
        place(sw_op(12, 3, 10));
        place(reg_op(7'h00, 2, 1, 3'b100, 3));
        place(sw_op(16, 3, 10));
        // slt x3, x2, x1
        place(reg_op(7'h00, 1, 2, 3'b010, 3));
        place(sw_op(20, 3, 10));
        place(reg_op(7'h00, 11, 1, 3'b001, 3));
        place(sw_op(24, 3, 10));
        // srl x3, x2, x11
        place(reg_op(7'h00, 11, 2, 3'b101, 3));
        place(sw_op(28, 3, 10));
        // immediate forms on x1
        place(imm_op(15, 1, 3'b111, 3, opc_imm));
        place(sw_op(32, 3, 10));
        place(imm_op(256, 1, 3'b110, 3, opc_imm));
        place(sw_op(36, 3, 10));
        place(imm_op(-1, 1, 3'b100, 3, opc_imm));
        place(sw_op(40, 3, 10));
        place(imm_op(-1, 1, 3'b010, 3, opc_imm));
        place(sw_op(44, 3, 10));
        // load, increment, store back
        place(imm_op(64, 10, 3'b010, 16, opc_load));
        place(imm_op(1, 16, 3'b000, 16, opc_imm));
        place(sw_op(48, 16, 10));
        // marker in x20, its store at 0x260 must never happen
        place(imm_op(12'h5ad, 0, 3'b000, 20, opc_imm));
        place(branch_op(8, 1, 1, 3'b000));
        place(sw_op(96, 20, 10));
        place(branch_op(8, 2, 1, 3'b001));
        place(sw_op(96, 20, 10));
        // not taken
        place(branch_op(8, 2, 1, 3'b000));
        place(sw_op(52, 1, 10));
        place(branch_op(8, 1, 1, 3'b001));
        place(sw_op(56, 2, 10));
        // jal at 0xa0 over one marker
        place(jal_op(8, 21));
        place(sw_op(96, 20, 10));
        place(sw_op(60, 21, 10));
        // jalr at 0xb0 to 0xb8 + 4
        place(imm_op(32'hb8, 0, 3'b000, 22, opc_imm));
        place(imm_op(4, 22, 3'b000, 23, opc_jalr));
        place(sw_op(96, 20, 10));
        place(sw_op(96, 20, 10));
        place(sw_op(68, 23, 10));
        // write to x0 is dropped
        place(imm_op(5, 1, 3'b000, 0, opc_imm));
        place(sw_op(72, 0, 10));
        place(lui_op(20'h12345, 24));
        place(sw_op(76, 24, 10));
        place(cpu_pkg::ecall_instr);
    endtask

    task automatic add_expected(input logic [31:0] adr, input logic [31:0] dat);
        exp_addr.push_back(adr);
        exp_data.push_back(dat);
    endtask

    task automatic build_expected();
        add_expected(32'h200, 32'h0000_005d);
        add_expected(32'h204, 32'h0000_006b);
        add_expected(32'h208, 32'h0000_0060);
        add_expected(32'h20c, 32'hffff_fffd);
        add_expected(32'h210, 32'hffff_ff9d);
        add_expected(32'h214, 32'h0000_0001);
        add_expected(32'h218, 32'h0000_0320);
        add_expected(32'h21c, 32'h1fff_ffff);
        add_expected(32'h220, 32'h0000_0004);
        add_expected(32'h224, 32'h0000_0164);
        add_expected(32'h228, 32'hffff_ff9b);
        add_expected(32'h22c, 32'h0000_0000);
        add_expected(32'h230, 32'h0000_1235);
        add_expected(32'h234, 32'h0000_0064);
        add_expected(32'h238, 32'hffff_fff9);
        // link values, jump address plus 4
        add_expected(32'h23c, 32'h0000_00a4);
        add_expected(32'h244, 32'h0000_00b4);
        add_expected(32'h248, 32'h0000_0000);
        add_expected(32'h24c, 32'h1234_5000);
    endtask

    task automatic check_store(input logic [31:0] adr, input logic [31:0] dat);
        if (stores_seen >= exp_addr.size()) begin
            store_errors++;
            $display("store to %h at %0t ns is not one the program makes", adr, $time);
        end else begin
            if (adr !== exp_addr[stores_seen]) begin
                store_errors++;
                $display("[ERROR] %0t ns: wb_o.adr expected %h, got %h",
                         $time, exp_addr[stores_seen], adr);
            end
            if (dat !== exp_data[stores_seen]) begin
                store_errors++;
                $display("[ERROR] %0t ns: wb_o.dat_w expected %h, got %h",
                         $time, exp_data[stores_seen], dat);
            end
        end
        stores_seen++;
    endtask

    task automatic serve_access();
        logic [7:0] idx;
        idx = wb_o.adr[9:2];
        // every transfer is a full word
        if (wb_o.sel !== 4'hf) begin
            bus_errors++;
            $display("[ERROR] %0t ns: wb_o.sel expected %h, got %h",
                     $time, 4'hf, wb_o.sel);
        end
        if (wb_o.we) begin
            check_store(wb_o.adr, wb_o.dat_w);
            mem[idx] = wb_o.dat_w;
        end else begin
            wb_i.dat_r = mem[idx];
        end
        wb_i.ack = 1'b1;
    endtask

    // memory slave, ack after 0 to 3 wait cycles
    initial begin
        load_program();
        build_expected();
        forever begin
            @(posedge clk);
            #1;
            if (wb_i.ack) begin
                wb_i.ack = 1'b0;
            end else if (wb_o.cyc && wb_o.stb) begin
                if (!busy) begin
                    busy = 1'b1;
                    rnd = $random(seed);
                    wait_left = rnd & 3;
                end
                if (wait_left == 0) begin
                    serve_access();
                    busy = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    task automatic wait_for_store(input int idx, output bit reached);
        int cycles;
        cycles = 0;
        while (stores_seen <= idx && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        reached = (stores_seen > idx);
        if (!reached) begin
            flow_errors++;
            $display("no store number %0d arrived within %0d cycles", idx, wait_limit);
        end
    endtask

    task automatic wait_for_halt(output bit reached);
        int cycles;
        cycles = 0;
        while (!halted && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        reached = halted;
        if (!reached) begin
            flow_errors++;
            $display("the core did not halt within %0d cycles", wait_limit);
        end
    endtask

    initial begin
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        ok = 1'b1;
        for (int i = 0; i < exp_addr.size(); i++) begin
            if (ok) begin
                wait_for_store(i, ok);
            end
        end
        if (ok) begin
            wait_for_halt(ok);
        end
        // idle a little with the core halted
        repeat (4) @(negedge clk);
        if (stores_seen != exp_addr.size()) begin
            flow_errors++;
            $display("saw %0d stores where the program makes %0d", stores_seen, exp_addr.size());
        end
        $display("closing counts: %0d store, %0d bus, %0d flow, %0d assertion errors",
                 store_errors, bus_errors, flow_errors, dut.props.fail_count);
        if (store_errors + bus_errors + flow_errors + dut.props.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
